// File: Makefile
# Verilator build and run for the ATC core testbench

VERILATOR ?= verilator
TOP       ?= atc_tb
FILELIST  ?= atc.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(wildcard src/*.sv bench/*.sv)
BINARY  := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets and variables"
	@echo "  test   build with Verilator, run the simulation, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

$(BINARY): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(BINARY)
	@./$(BINARY) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "RESULT: FAIL" $(LOG); then \
	  echo "Simulation failed"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: atc.f
src/atc_pkg.sv
src/runway_if.sv
src/msg_fifo.sv
src/runway_table.sv
src/request_sequencer.sv
src/reply_sender.sv
src/atc_top.sv
bench/atc_checker.sv
bench/atc_tb.sv

// File: bench/atc_checker.sv
//////////////////////////////
// Reference model and scoreboard for atc_top
// Watches only the top-level ports
// Assumes no message is sent while busy is high
//////////////////////////////
`default_nettype none
`timescale 1ns/100ps

module atc_checker (
  input  logic                            clock,
  input  logic                            reset,
  input  atc_pkg::msg_t                   rx_data,
  input  logic                            rx_valid,
  input  logic                            tx_ready,
  input  atc_pkg::msg_t                   tx_data,
  input  logic                            tx_send,
  input  logic                            busy,
  input  logic [atc_pkg::NUM_RUNWAYS-1:0] runway_active,
  output int                              errors,
  output int                              checked,
  output int                              pending
);
  import atc_pkg::*;

  plane_id_t              takeoff_q [$];
  plane_id_t              landing_q [$];
  msg_t                   expected [$];
  plane_id_t              owner [NUM_RUNWAYS];
  logic [NUM_RUNWAYS-1:0] active;
  logic                   emergency;
  logic                   takeoff_first;
  logic                   ready_before;
  int                     stream_errors = 0;
  int                     check_errors = 0;
  int                     errors_before = 0;
  int                     test_count = 0;

  assign errors = stream_errors + check_errors;

  task automatic push_reply(input plane_id_t id, input msg_type_t kind,
                            input logic [1:0] action);
    msg_t m;
    m.plane_id = id;
    m.msg_type = kind;
    m.action   = action;
    expected.push_back(m);
  endtask

  ////////////////////////////////
  // Message rules
  ////////////////////////////////

  task automatic apply_message(input msg_t m);
    case (m.msg_type)
      REQUEST: begin
        if (!m.action[1]) begin
          if (takeoff_q.size() == QUEUE_DEPTH) begin
            push_reply(m.plane_id, DIVERT, 2'b00);
          end else begin
            takeoff_q.push_back(m.plane_id);
            push_reply(m.plane_id, HOLD, 2'b00);
          end
        end else if (landing_q.size() == QUEUE_DEPTH || emergency) begin
          push_reply(m.plane_id, DIVERT, 2'b00);
        end else begin
          landing_q.push_back(m.plane_id);
          push_reply(m.plane_id, HOLD, 2'b00);
        end
      end
      DECLARE: begin
        // Only the owner can vacate
        if (active[m.action[0]] && owner[m.action[0]] == m.plane_id)
          active[m.action[0]] = 1'b0;
      end
      EMERGENCY: begin
        if (m.action == 2'b01)
          emergency = 1'b1;
        else if (m.action == 2'b00)
          emergency = 1'b0;
        else
          push_reply(m.plane_id, SAY_AGAIN, 2'b00);
      end
      default: push_reply(m.plane_id, SAY_AGAIN, 2'b00);
    endcase
  endtask

  // Clear or divert until nothing more can move
  task automatic run_clearances();
    logic      more;
    logic      both;
    int        r;
    plane_id_t id;
    more = 1'b1;
    while (more) begin
      if (emergency) begin
        if (landing_q.size() == 0)
          more = 1'b0;
        else
          push_reply(landing_q.pop_front(), DIVERT, 2'b00);
      end else if (&active || (takeoff_q.size() == 0 && landing_q.size() == 0)) begin
        more = 1'b0;
      end else begin
        r = -1;
        for (int i = 0; i < NUM_RUNWAYS; i++) begin
          if (r < 0 && !active[i])
            r = i;
        end
        both = (takeoff_q.size() != 0) && (landing_q.size() != 0);
        if (takeoff_q.size() != 0 && (takeoff_first || landing_q.size() == 0))
          id = takeoff_q.pop_front();
        else
          id = landing_q.pop_front();
        if (both)
          takeoff_first = !takeoff_first;
        active[r] = 1'b1;
        owner[r]  = id;
        push_reply(id, CLEAR, 2'(r));
      end
    end
  endtask

  task automatic compare_reply();
    msg_t want;
    if (!ready_before) begin
      $display("reply sent at %0t while the transmitter was not ready", $time);
      stream_errors++;
    end
    if (expected.size() == 0) begin
      $display("reply 0x%03h sent at %0t with no reply expected", tx_data, $time);
      stream_errors++;
    end else begin
      want = expected.pop_front();
      checked++;
      if (tx_data !== want) begin
        $display("** Error tx_data: expected 0x%03h, got 0x%03h", want, tx_data);
        stream_errors++;
      end
    end
  endtask

  ////////////////////////////////
  // Port monitor
  ////////////////////////////////

  always @(posedge clock) begin
    if (reset) begin
      takeoff_q.delete();
      landing_q.delete();
      expected.delete();
      active        = '0;
      emergency     = 1'b0;
      takeoff_first = 1'b0;
      checked       = 0;
      for (int i = 0; i < NUM_RUNWAYS; i++)
        owner[i] = '0;
    end else begin
      if (tx_send)
        compare_reply();
      if (rx_valid && !busy) begin
        apply_message(rx_data);
        run_clearances();
      end
    end
    ready_before = tx_ready;
    pending      = expected.size();
  end

  // Called by the test sequence once the DUT has settled
  task automatic check_runways();
    if (runway_active !== active) begin
      $display("** Error runway_active: expected 0x%0h, got 0x%0h", active, runway_active);
      check_errors++;
    end
  endtask

  task automatic expect_busy(input logic value);
    if (busy !== value) begin
      $display("** Error busy: expected 0x%0h, got 0x%0h", value, busy);
      check_errors++;
    end
  endtask

  task automatic end_test(input string name);
    check_runways();
    if (expected.size() != 0) begin
      $display("%0d expected replies were never sent", expected.size());
      check_errors++;
    end
    test_count++;
    $display("test %0d %s finished with %0d errors", test_count, name,
             stream_errors + check_errors - errors_before);
    errors_before = stream_errors + check_errors;
  endtask

endmodule

`default_nettype wire

// File: bench/atc_tb.sv
//////////////////////////////
// Testbench for atc_top with random IDs from a fixed seed
// Inputs change on the falling edge
// Tests run in order and share the model state
//////////////////////////////
`default_nettype none
`timescale 1ns/100ps

module atc_tb;
  import atc_pkg::*;

  localparam int NUM_TESTS    = 5;
  localparam int MAX_MESSAGES = 20;
  localparam int IDLE_CYCLES  = 40;
  localparam int RESET_CYCLES = 16;
  localparam int BURST_LENGTH = 9;
  localparam int BURST_GAP    = 6;
  localparam int REPLY_WAIT   = 200;
  localparam int MAX_CYCLES   = NUM_TESTS * MAX_MESSAGES * IDLE_CYCLES + 1000;

  logic                   clock;
  logic                   reset;
  msg_t                   rx_data;
  logic                   rx_valid;
  logic                   tx_ready;
  msg_t                   tx_data;
  logic                   tx_send;
  logic                   busy;
  logic [NUM_RUNWAYS-1:0] runway_active;
  int                     errors;
  int                     checked;
  int                     pending;
  int                     cycle_count;
  integer                 seed;
  logic [15:0]            used_ids;

  atc_top dut0 (
    .clock         (clock),
    .reset         (reset),
    .rx_data       (rx_data),
    .rx_valid      (rx_valid),
    .tx_ready      (tx_ready),
    .tx_data       (tx_data),
    .tx_send       (tx_send),
    .busy          (busy),
    .runway_active (runway_active)
  );

  atc_checker checker0 (
    .clock         (clock),
    .reset         (reset),
    .rx_data       (rx_data),
    .rx_valid      (rx_valid),
    .tx_ready      (tx_ready),
    .tx_data       (tx_data),
    .tx_send       (tx_send),
    .busy          (busy),
    .runway_active (runway_active),
    .errors        (errors),
    .checked       (checked),
    .pending       (pending)
  );

  initial begin
    clock = 1'b0;
    forever #50 clock = ~clock;
  end

  ////////////////////////////////
  // Stimulus helpers
  ////////////////////////////////

  function automatic plane_id_t random_plane();
    logic [31:0] r;
    r = $random(seed);
    return r[PLANE_BITS-1:0];
  endfunction

  function automatic plane_id_t distinct_plane();
    plane_id_t id;
    id = random_plane();
    while (used_ids[id])
      id = random_plane();
    used_ids[id] = 1'b1;
    return id;
  endfunction

  // Opcodes 3 to 7 are invalid inbound
  function automatic msg_type_t invalid_opcode();
    logic [31:0] r;
    r = $random(seed);
    return msg_type_t'(3'd3 + 3'(r[15:0] % 16'd5));
  endfunction

  task automatic send_message(input plane_id_t id, input msg_type_t kind,
                              input logic [1:0] action, input int idle);
    @(negedge clock);
    rx_data.plane_id = id;
    rx_data.msg_type = kind;
    rx_data.action   = action;
    rx_valid         = 1'b1;
    @(negedge clock);
    rx_valid = 1'b0;
    repeat (idle) @(negedge clock);
  endtask

  // Each owner vacates in turn so queued planes move up
  task automatic release_runways();
    for (int i = 0; i < 6; i++)
      send_message(checker0.owner[i % NUM_RUNWAYS], DECLARE, 2'(i % NUM_RUNWAYS), IDLE_CYCLES);
  endtask

  task automatic wait_replies();
    int n;
    n = 0;
    while (pending != 0 && n < REPLY_WAIT) begin
      @(negedge clock);
      n++;
    end
  endtask

  ////////////////////////////////
  // Tests
  ////////////////////////////////

  task automatic clear_random_planes();
    logic [31:0] r;
    used_ids = '0;
    for (int i = 0; i < 6; i++) begin
      r = $random(seed);
      send_message(distinct_plane(), REQUEST, r[1:0], IDLE_CYCLES);
    end
    checker0.end_test("clearances");
  endtask

  task automatic declare_and_release();
    plane_id_t other;
    other = checker0.owner[0] + 4'd1;
    send_message(other, DECLARE, 2'b00, IDLE_CYCLES);
    checker0.check_runways();
    release_runways();
    checker0.end_test("declares");
  endtask

  task automatic overflow_queues();
    // Two cleared, four held, two diverted
    for (int i = 0; i < 8; i++)
      send_message(random_plane(), REQUEST, 2'b00, IDLE_CYCLES);
    for (int i = 0; i < 6; i++)
      send_message(random_plane(), REQUEST, 2'b10, IDLE_CYCLES);
    for (int i = 0; i < 3; i++)
      send_message(random_plane(), invalid_opcode(), 2'b00, IDLE_CYCLES);
    send_message(random_plane(), EMERGENCY, 2'b10, IDLE_CYCLES);
    send_message(random_plane(), EMERGENCY, 2'b11, IDLE_CYCLES);
    checker0.end_test("full queues");
  endtask

  task automatic divert_in_emergency();
    send_message(random_plane(), EMERGENCY, 2'b01, IDLE_CYCLES);
    send_message(random_plane(), REQUEST, 2'b10, IDLE_CYCLES);
    // Freed runway must stay empty
    send_message(checker0.owner[0], DECLARE, 2'b00, IDLE_CYCLES);
    checker0.check_runways();
    send_message(random_plane(), EMERGENCY, 2'b00, IDLE_CYCLES);
    release_runways();
    checker0.end_test("emergency");
  endtask

  task automatic stall_transmitter();
    @(negedge clock);
    tx_ready = 1'b0;
    for (int i = 0; i < BURST_LENGTH; i++) begin
      // Busy may only rise with the ninth message
      if (i == BURST_LENGTH - 1)
        checker0.expect_busy(1'b0);
      send_message(random_plane(), invalid_opcode(), 2'b00, BURST_GAP);
    end
    repeat (20) @(negedge clock);
    checker0.expect_busy(1'b1);
    tx_ready = 1'b1;
    wait_replies();
    repeat (4) @(negedge clock);
    checker0.expect_busy(1'b0);
    checker0.end_test("back pressure");
  endtask

  initial begin
    cycle_count = 0;
    while (cycle_count < MAX_CYCLES) begin
      @(posedge clock);
      cycle_count++;
    end
    $display("Run stopped after %0d cycles without finishing the tests", cycle_count);
    $display("RESULT: FAIL");
    $finish;
  end

  initial begin
    seed     = 76;
    used_ids = '0;
    reset    = 1'b1;
    rx_data  = '0;
    rx_valid = 1'b0;
    tx_ready = 1'b1;
    repeat (RESET_CYCLES) @(posedge clock);
    @(negedge clock);
    reset = 1'b0;
    clear_random_planes();
    declare_and_release();
    overflow_queues();
    divert_in_emergency();
    stall_transmitter();
    $display("%0d tests, %0d replies checked, %0d errors", NUM_TESTS, checked, errors);
    if (errors == 0)
      $display("RESULT: PASS");
    else
      $display("RESULT: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

// File: src/atc_pkg.sv
//////////////////////////////
// Shared types and sizes for the ATC core
// Inbound opcodes are 0 to 2, the rest are invalid on input
// FIFO depths must stay powers of two
//////////////////////////////
`default_nettype none

package atc_pkg;

  // Runway and FIFO sizing
  localparam int NUM_RUNWAYS = 2;
  localparam int RUNWAY_BITS = $clog2(NUM_RUNWAYS);
  localparam int REQ_DEPTH   = 4;
  localparam int QUEUE_DEPTH = 4;
  localparam int REPLY_DEPTH = 4;

  // Field widths
  localparam int PLANE_BITS = 4;
  localparam int MSG_BITS   = 9;

  typedef logic [PLANE_BITS-1:0] plane_id_t;

  // Opcodes, inbound first then replies
  typedef enum logic [2:0] {
    REQUEST   = 3'd0,
    DECLARE   = 3'd1,
    EMERGENCY = 3'd2,
    CLEAR     = 3'd4,
    HOLD      = 3'd5,
    SAY_AGAIN = 3'd6,
    DIVERT    = 3'd7
  } msg_type_t;

  // Request action[1]: 0 takeoff, 1 landing
  // Declare action[0]: runway vacated
  // Emergency action: 01 declare, 00 resolve
  // Clear reply action[0]: granted runway
  typedef struct packed {
    plane_id_t  plane_id;
    msg_type_t  msg_type;
    logic [1:0] action;
  } msg_t;

endpackage

`default_nettype wire

// File: src/atc_top.sv
//////////////////////////////
// ATC core top level
// rx_data comes already deframed, rx_valid is a one-cycle pulse
// A message arriving while busy is high is lost
//////////////////////////////
`default_nettype none
`timescale 1ns/100ps

module atc_top (
  input  logic                            clock,
  input  logic                            reset,
  input  atc_pkg::msg_t                   rx_data,
  input  logic                            rx_valid,
  input  logic                            tx_ready,
  output atc_pkg::msg_t                   tx_data,
  output logic                            tx_send,
  output logic                            busy,
  output logic [atc_pkg::NUM_RUNWAYS-1:0] runway_active
);
  import atc_pkg::*;

  msg_t      request;
  logic      request_empty;
  logic      request_read;
  plane_id_t queue_plane_id;
  plane_id_t takeoff_id;
  plane_id_t landing_id;
  logic      takeoff_write;
  logic      takeoff_read;
  logic      takeoff_full;
  logic      takeoff_empty;
  logic      landing_write;
  logic      landing_read;
  logic      landing_full;
  logic      landing_empty;
  msg_t      reply;
  logic      reply_write;
  logic      reply_full;

  runway_if runways ();

  assign runway_active = runways.runway_active;

  ////////////////////////////////
  // Request and aircraft queues
  ////////////////////////////////

  msg_fifo #(
    .WIDTH (MSG_BITS),
    .DEPTH (REQ_DEPTH)
  ) request_fifo (
    .clock    (clock),
    .reset    (reset),
    .data_in  (rx_data),
    .write    (rx_valid),
    .read     (request_read),
    .data_out (request),
    .full     (busy),
    .empty    (request_empty)
  );

  msg_fifo #(
    .WIDTH (PLANE_BITS),
    .DEPTH (QUEUE_DEPTH)
  ) takeoff_queue (
    .clock    (clock),
    .reset    (reset),
    .data_in  (queue_plane_id),
    .write    (takeoff_write),
    .read     (takeoff_read),
    .data_out (takeoff_id),
    .full     (takeoff_full),
    .empty    (takeoff_empty)
  );

  msg_fifo #(
    .WIDTH (PLANE_BITS),
    .DEPTH (QUEUE_DEPTH)
  ) landing_queue (
    .clock    (clock),
    .reset    (reset),
    .data_in  (queue_plane_id),
    .write    (landing_write),
    .read     (landing_read),
    .data_out (landing_id),
    .full     (landing_full),
    .empty    (landing_empty)
  );

  ////////////////////////////////
  // Control and reply path
  ////////////////////////////////

  request_sequencer sequencer (
    .clock          (clock),
    .reset          (reset),
    .request        (request),
    .request_empty  (request_empty),
    .request_read   (request_read),
    .takeoff_id     (takeoff_id),
    .landing_id     (landing_id),
    .takeoff_full   (takeoff_full),
    .takeoff_empty  (takeoff_empty),
    .landing_full   (landing_full),
    .landing_empty  (landing_empty),
    .takeoff_write  (takeoff_write),
    .takeoff_read   (takeoff_read),
    .landing_write  (landing_write),
    .landing_read   (landing_read),
    .queue_plane_id (queue_plane_id),
    .reply_full     (reply_full),
    .reply          (reply),
    .reply_write    (reply_write),
    .runways        (runways.sequencer)
  );

  runway_table runway_regs (
    .clock   (clock),
    .reset   (reset),
    .runways (runways.tbl)
  );

  reply_sender sender (
    .clock       (clock),
    .reset       (reset),
    .reply       (reply),
    .reply_write (reply_write),
    .reply_full  (reply_full),
    .tx_ready    (tx_ready),
    .tx_data     (tx_data),
    .tx_send     (tx_send)
  );

endmodule

`default_nettype wire

// File: src/msg_fifo.sv
//////////////////////////////
// Circular FIFO, output register loads on each accepted read
// DEPTH must be a power of two, at least 2
// Data is valid the cycle after the read
//////////////////////////////
`default_nettype none
`timescale 1ns/100ps

module msg_fifo #(
  parameter int WIDTH = 9,
  parameter int DEPTH = 4
) (
  input  logic             clock,
  input  logic             reset,
  input  logic [WIDTH-1:0] data_in,
  input  logic             write,
  input  logic             read,
  output logic [WIDTH-1:0] data_out,
  output logic             full,
  output logic             empty
);

  logic [WIDTH-1:0]         mem [DEPTH];
  logic [$clog2(DEPTH)-1:0] put_ptr;
  logic [$clog2(DEPTH)-1:0] get_ptr;
  logic [$clog2(DEPTH):0]   count;
  logic                     do_read;
  logic                     do_write;

  assign empty = (count == 0);
  assign full  = (count == DEPTH);

  // A read at the same edge frees the slot for a write
  assign do_read  = read && !empty;
  assign do_write = write && (!full || do_read);

  always_ff @(posedge clock, posedge reset) begin
    if (reset) begin
      put_ptr <= '0;
      get_ptr <= '0;
      count   <= '0;
    end else begin
      if (do_write)
        put_ptr <= put_ptr + 1'b1;
      if (do_read)
        get_ptr <= get_ptr + 1'b1;
      case ({do_write, do_read})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (do_write)
      mem[put_ptr] <= data_in;
    if (do_read)
      data_out <= mem[get_ptr];
  end

  count_in_range: assert property (@(posedge clock) disable iff (reset) count <= DEPTH)
    else $error("FIFO count %0d above depth %0d", count, DEPTH);

endmodule

`default_nettype wire

// File: src/reply_sender.sv
//////////////////////////////
// Reply FIFO drained toward the transmitter
// At most one tx_send pulse every two cycles
// Replies stay queued while tx_ready is low
//////////////////////////////
`default_nettype none
`timescale 1ns/100ps

module reply_sender (
  input  logic          clock,
  input  logic          reset,
  input  atc_pkg::msg_t reply,
  input  logic          reply_write,
  output logic          reply_full,
  input  logic          tx_ready,
  output atc_pkg::msg_t tx_data,
  output logic          tx_send
);
  import atc_pkg::*;

  typedef enum logic {
    WAIT = 1'b0,
    SEND = 1'b1
  } send_state_t;

  send_state_t state;
  send_state_t next_state;
  logic        fifo_empty;
  logic        fifo_read;

  msg_fifo #(
    .WIDTH (MSG_BITS),
    .DEPTH (REPLY_DEPTH)
  ) reply_fifo (
    .clock    (clock),
    .reset    (reset),
    .data_in  (reply),
    .write    (reply_write),
    .read     (fifo_read),
    .data_out (tx_data),
    .full     (reply_full),
    .empty    (fifo_empty)
  );

  // Read in WAIT, the FIFO output is valid in SEND
  always_comb begin
    next_state = state;
    fifo_read  = 1'b0;
    tx_send    = 1'b0;
    case (state)
      WAIT: begin
        if (!fifo_empty && tx_ready) begin
          fifo_read  = 1'b1;
          next_state = SEND;
        end
      end
      SEND: begin
        tx_send    = 1'b1;
        next_state = WAIT;
      end
      default: next_state = WAIT;
    endcase
  end

  always_ff @(posedge clock, posedge reset) begin
    if (reset)
      state <= WAIT;
    else
      state <= next_state;
  end

  send_spaced: assert property (@(posedge clock) disable iff (reset) tx_send |=> !tx_send)
    else $error("tx_send high on two cycles in a row");

endmodule

`default_nettype wire

// File: src/request_sequencer.sv
//////////////////////////////
// Reads requests, keeps the emergency latch, grants runways
// One clearance or divert per pass through CHECK_QUEUES
// Waits in REPLY or QUEUE_CLR while the reply FIFO is full
//////////////////////////////
`default_nettype none
`timescale 1ns/100ps

module request_sequencer (
  input  logic               clock,
  input  logic               reset,
  input  atc_pkg::msg_t      request,
  input  logic               request_empty,
  output logic               request_read,
  input  atc_pkg::plane_id_t takeoff_id,
  input  atc_pkg::plane_id_t landing_id,
  input  logic               takeoff_full,
  input  logic               takeoff_empty,
  input  logic               landing_full,
  input  logic               landing_empty,
  output logic               takeoff_write,
  output logic               takeoff_read,
  output logic               landing_write,
  output logic               landing_read,
  output atc_pkg::plane_id_t queue_plane_id,
  input  logic               reply_full,
  output atc_pkg::msg_t      reply,
  output logic               reply_write,
  runway_if.sequencer        runways
);
  import atc_pkg::*;

  typedef enum logic [2:0] {
    QUIET          = 3'd0,
    INTERPRET      = 3'd1,
    REPLY          = 3'd2,
    CHECK_QUEUES   = 3'd3,
    CLR_TAKEOFF    = 3'd4,
    CLR_LANDING    = 3'd5,
    DIVERT_LANDING = 3'd6,
    QUEUE_CLR      = 3'd7
  } state_t;

  state_t                 state;
  state_t                 next_state;
  logic                   emergency;
  logic                   takeoff_first;
  logic                   set_emergency;
  logic                   clear_emergency;
  logic                   toggle_first;
  logic                   any_free;
  logic [RUNWAY_BITS-1:0] free_runway;
  logic                   load_reply;
  msg_t                   next_reply;

  // Both queues take the plane ID of the current request
  assign queue_plane_id = request.plane_id;

  // Lowest numbered free runway
  assign any_free = ~&runways.runway_active;

  always_comb begin
    free_runway = '0;
    for (int i = NUM_RUNWAYS - 1; i >= 0; i--) begin
      if (!runways.runway_active[i])
        free_runway = RUNWAY_BITS'(i);
    end
  end

  ////////////////////////////////
  // Next state and strobes
  ////////////////////////////////

  always_comb begin
    next_state          = state;
    request_read        = 1'b0;
    takeoff_write       = 1'b0;
    takeoff_read        = 1'b0;
    landing_write       = 1'b0;
    landing_read        = 1'b0;
    reply_write         = 1'b0;
    set_emergency       = 1'b0;
    clear_emergency     = 1'b0;
    toggle_first        = 1'b0;
    load_reply          = 1'b0;
    next_reply.plane_id = request.plane_id;
    next_reply.msg_type = SAY_AGAIN;
    next_reply.action   = 2'b00;
    runways.plane_id    = request.plane_id;
    runways.runway_id   = free_runway;
    runways.lock        = 1'b0;
    runways.unlock      = 1'b0;

    case (state)
      QUIET: begin
        if (request_empty) begin
          next_state = CHECK_QUEUES;
        end else begin
          request_read = 1'b1;
          next_state   = INTERPRET;
        end
      end

      INTERPRET: begin
        case (request.msg_type)
          REQUEST: begin
            next_state = REPLY;
            load_reply = 1'b1;
            if (!request.action[1]) begin
              if (takeoff_full) begin
                next_reply.msg_type = DIVERT;
              end else begin
                takeoff_write       = 1'b1;
                next_reply.msg_type = HOLD;
              end
            end else begin
              // No new landings while the emergency holds
              if (landing_full || emergency) begin
                next_reply.msg_type = DIVERT;
              end else begin
                landing_write       = 1'b1;
                next_reply.msg_type = HOLD;
              end
            end
          end
          DECLARE: begin
            runways.unlock    = 1'b1;
            runways.runway_id = RUNWAY_BITS'(request.action[0]);
            next_state        = CHECK_QUEUES;
          end
          EMERGENCY: begin
            if (request.action == 2'b01) begin
              set_emergency = 1'b1;
              next_state    = CHECK_QUEUES;
            end else if (request.action == 2'b00) begin
              clear_emergency = 1'b1;
              next_state      = CHECK_QUEUES;
            end else begin
              load_reply = 1'b1;
              next_state = REPLY;
            end
          end
          default: begin
            load_reply = 1'b1;
            next_state = REPLY;
          end
        endcase
      end

      REPLY: begin
        if (!reply_full) begin
          reply_write = 1'b1;
          next_state  = CHECK_QUEUES;
        end
      end

      CHECK_QUEUES: begin
        next_state = QUIET;
        if (emergency) begin
          if (!landing_empty) begin
            landing_read = 1'b1;
            next_state   = DIVERT_LANDING;
          end
        end else if (any_free) begin
          if (!takeoff_empty && (takeoff_first || landing_empty)) begin
            takeoff_read = 1'b1;
            next_state   = CLR_TAKEOFF;
          end else if (!landing_empty) begin
            landing_read = 1'b1;
            next_state   = CLR_LANDING;
          end
          // Alternate only when both kinds are waiting
          toggle_first = !takeoff_empty && !landing_empty;
        end
      end

      CLR_TAKEOFF: begin
        runways.lock        = 1'b1;
        runways.plane_id    = takeoff_id;
        load_reply          = 1'b1;
        next_reply.plane_id = takeoff_id;
        next_reply.msg_type = CLEAR;
        next_reply.action   = 2'(free_runway);
        next_state          = QUEUE_CLR;
      end

      CLR_LANDING: begin
        runways.lock        = 1'b1;
        runways.plane_id    = landing_id;
        load_reply          = 1'b1;
        next_reply.plane_id = landing_id;
        next_reply.msg_type = CLEAR;
        next_reply.action   = 2'(free_runway);
        next_state          = QUEUE_CLR;
      end

      DIVERT_LANDING: begin
        load_reply          = 1'b1;
        next_reply.plane_id = landing_id;
        next_reply.msg_type = DIVERT;
        next_state          = QUEUE_CLR;
      end

      QUEUE_CLR: begin
        if (!reply_full) begin
          reply_write = 1'b1;
          next_state  = QUIET;
        end
      end

      default: next_state = QUIET;
    endcase
  end

  ////////////////////////////////
  // State, latch and reply
  ////////////////////////////////

  always_ff @(posedge clock, posedge reset) begin
    if (reset) begin
      state         <= QUIET;
      emergency     <= 1'b0;
      takeoff_first <= 1'b0;
    end else begin
      state <= next_state;
      if (set_emergency)
        emergency <= 1'b1;
      else if (clear_emergency)
        emergency <= 1'b0;
      if (toggle_first)
        takeoff_first <= !takeoff_first;
    end
  end

  always_ff @(posedge clock) begin
    if (load_reply)
      reply <= next_reply;
  end

  ////////////////////////////////
  // Checks
  ////////////////////////////////

  strobes_exclusive: assert property (
    @(posedge clock) disable iff (reset) !(runways.lock && runways.unlock)
  ) else $error("lock and unlock in the same cycle");

  no_write_when_full: assert property (
    @(posedge clock) disable iff (reset) reply_write |-> !reply_full
  ) else $error("reply written into a full FIFO");

endmodule

`default_nettype wire

// File: src/runway_if.sv
//////////////////////////////
// Lock and unlock strobes toward the runway table
// Strobes last one cycle and never overlap
//////////////////////////////
`default_nettype none
`timescale 1ns/100ps

interface runway_if;
  import atc_pkg::*;

  plane_id_t              plane_id;
  logic [RUNWAY_BITS-1:0] runway_id;
  logic                   lock;
  logic                   unlock;
  logic [NUM_RUNWAYS-1:0] runway_active;

  // Sequencer side issues strobes
  modport sequencer (
    output plane_id, runway_id, lock, unlock,
    input  runway_active
  );

  // Table side holds the runway state
  modport tbl (
    input  plane_id, runway_id, lock, unlock,
    output runway_active
  );

endinterface

`default_nettype wire

// File: src/runway_table.sv
//////////////////////////////
// Owner and active bit per runway
// Unlock only takes effect for the owning plane
//////////////////////////////
`default_nettype none
`timescale 1ns/100ps

module runway_table (
  input  logic clock,
  input  logic reset,
  runway_if.tbl runways
);
  import atc_pkg::*;

  plane_id_t              owner [NUM_RUNWAYS];
  logic [NUM_RUNWAYS-1:0] active;

  assign runways.runway_active = active;

  always_ff @(posedge clock, posedge reset) begin
    if (reset) begin
      active <= '0;
    end else begin
      for (int i = 0; i < NUM_RUNWAYS; i++) begin
        if (runways.runway_id == RUNWAY_BITS'(i)) begin
          if (runways.lock)
            active[i] <= 1'b1;
          // Another plane cannot release this runway
          else if (runways.unlock && runways.plane_id == owner[i])
            active[i] <= 1'b0;
        end
      end
    end
  end

  // Owner only matters while the runway is active
  always_ff @(posedge clock) begin
    for (int i = 0; i < NUM_RUNWAYS; i++) begin
      if (runways.lock && runways.runway_id == RUNWAY_BITS'(i))
        owner[i] <= runways.plane_id;
    end
  end

  ////////////////////////////////
  // Checks
  ////////////////////////////////

  lock_free_runway: assert property (
    @(posedge clock) disable iff (reset)
    runways.lock |-> !active[runways.runway_id]
  ) else $error("lock on busy runway %0d", runways.runway_id);

endmodule

`default_nettype wire
